//--- fir_stim.txt
// columns: input sample x(n) as sfix16_En15, expected y(n) as sfix33_En31
// y(n) is the filter output after the load of sample n+2
// impulse
7fff 1eedda245
0000 1f5471572
0000 019ed4c25
0000 0340397f8
0000 0340397f8
0000 019ed4c25
0000 1f5471572
0000 1eedda245
// run of -1.0
8000 011228000
8000 01bdb8000
8000 001ee0000
8000 1cdea0000
8000 199e60000
8000 17ff88000
8000 18ab18000
8000 19bd40000
8000 19bd40000
8000 19bd40000
// random samples
1a2b 18730bc69
c3d4 185d561b6
5e6f 197992976
8f10 1d39133f6
2c71 00ac06c58
f05a 0169384fd

//--- compile.f
fir_pkg.sv
ripple_adder.sv
vedic_mult.sv
phase_ctrl.sv
tap_delay_line.sv
mac_partition.sv
fir_partly_serial.sv
tb_fir_partly_serial.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_fir_partly_serial \
  -Mdir "$build_dir" -o sim_fir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_fir" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "All tests passed" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- tb_fir_partly_serial.sv
`timescale 1ns/1ps

module tb_fir_partly_serial;

  localparam int num_vectors  = 24;  // sample lines in the stim file
  localparam int stim_w       = 36;  // nine hex digits per word
  localparam int load_timeout = 40;  // cycles allowed from one load to the next
  localparam fir_pkg::phase_t last_phase = fir_pkg::phase_t'(fir_pkg::taps_per_part - 1);

  logic             clk;
  logic             reset;
  logic             clk_enable;
  fir_pkg::sample_t filter_in;
  fir_pkg::acc_t    filter_out;

  logic [stim_w-1:0] stim_mem [0:2*num_vectors-1];  // sample, expected, sample, ...
  logic [31:0]       lfsr;
  fir_pkg::phase_t   phase_model;  // mirror of the DUT tap phase
  fir_pkg::acc_t     held_out;     // filter_out must keep this until the next load
  int                checks;
  int                mismatches;
  int                other_errors;
  int                gaps;         // disabled cycles driven
  bit                timed_out;

  fir_partly_serial dut (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  always #50 clk = ~clk;

  ////////////////////
  // helpers

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic compare(input fir_pkg::acc_t got, input fir_pkg::acc_t expected,
                         input string what);
    checks++;
    if (got !== expected) begin
      mismatches++;
      $display("FAILED at %0t ns: %s, filter_out %h, expected %h", $time, what, got, expected);
    end
  endtask

  // falling edge to falling edge, enable chosen by two LFSR bits
  task automatic run_cycle(output bit loaded);
    bit gap_a;
    bit gap_b;
    lfsr = lfsr_next(lfsr);
    gap_a = lfsr[0];
    lfsr = lfsr_next(lfsr);
    gap_b = lfsr[0];
    clk_enable = !(gap_a && gap_b);  // about one cycle in four held
    loaded = clk_enable && (phase_model == last_phase);
    if (clk_enable) begin
      if (phase_model == last_phase) begin
        phase_model = '0;
      end else begin
        phase_model = phase_model + 1'b1;
      end
    end else begin
      gaps++;
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  // cycles until the next load edge, output must hold in between
  task automatic wait_load(input string what);
    bit loaded;
    int cycles;
    loaded = 1'b0;
    cycles = 0;
    while (!loaded && cycles < load_timeout) begin
      run_cycle(loaded);
      cycles++;
      if (!loaded) begin
        compare(filter_out, held_out, {what, ", hold before load"});
      end
    end
    if (!loaded) begin
      $display("timeout at %0t ns: no sample load within %0d cycles for %s",
               $time, load_timeout, what);
      other_errors++;
      timed_out = 1'b1;
    end
  endtask

  ////////////////////
  // main sequence
  initial begin
    fir_pkg::acc_t expected;
    string         what;
    int            n;
    clk          = 1'b0;
    reset        = 1'b1;
    clk_enable   = 1'b0;
    filter_in    = '0;
    lfsr         = 32'h9102e241;
    phase_model  = last_phase;  // first enabled edge loads
    held_out     = '0;
    checks       = 0;
    mismatches   = 0;
    other_errors = 0;
    gaps         = 0;
    timed_out    = 1'b0;

    for (n = 0; n < 2 * num_vectors; n++) begin
      stim_mem[n] = {4'hf, 32'(n)};  // top nibble marks a word not read
    end
    $readmemh("fir_stim.txt", stim_mem);

    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    compare(filter_out, '0, "right after reset");

    if (stim_mem[2*num_vectors-1][stim_w-1 -: 3] != 3'b000) begin
      $display("stim file fir_stim.txt is missing or holds fewer than %0d lines", num_vectors);
      other_errors++;
    end else begin
      // two extra zero samples push the last outputs through
      for (n = 0; n < num_vectors + 2 && !timed_out; n++) begin
        if (n < num_vectors) begin
          filter_in = stim_mem[2*n][fir_pkg::sample_w-1:0];
        end else begin
          filter_in = '0;
        end
        what = $sformatf("sample %0d", n);
        wait_load(what);
        if (!timed_out) begin
          if (n < 2) begin
            expected = '0;  // pipeline still empty
          end else begin
            expected = stim_mem[2*(n-2)+1][fir_pkg::acc_w-1:0];  // y(n-2)
          end
          compare(filter_out, expected, {what, ", output after load"});
          held_out = expected;
        end
      end
    end

    $display("%0d checks, %0d mismatches, %0d other errors, %0d disabled cycles",
             checks, mismatches, other_errors, gaps);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- fir_partly_serial.sv
`timescale 1ns/1ps

// eight-tap FIR, two serial partitions of four taps each
module fir_partly_serial (
  input  logic             clk,
  input  logic             reset,
  input  logic             clk_enable,
  input  fir_pkg::sample_t filter_in,   // sfix16_En15
  output fir_pkg::acc_t    filter_out   // sfix33_En31
);

  fir_pkg::phase_bus_t                      phase;
  fir_pkg::tap_pair_t                       taps;
  fir_pkg::acc_t [fir_pkg::num_parts-1:0]   part_acc;   // per-partition sums
  fir_pkg::acc_t                            part_sum;   // both partitions added
  fir_pkg::acc_t                            final_sum;

  ////////////////////
  // control and delay line
  phase_ctrl u_phase (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .phase      (phase)
  );

  tap_delay_line u_line (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .filter_in (filter_in),
    .taps      (taps)
  );

  ////////////////////
  // serial partitions
  mac_partition #(.part(0)) u_part0 (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .phase      (phase),
    .tap        (taps.tap[0]),
    .acc        (part_acc[0])
  );

  mac_partition #(.part(1)) u_part1 (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .phase      (phase),
    .tap        (taps.tap[1]),
    .acc        (part_acc[1])
  );

  ////////////////////
  // final sum and output register
  ripple_adder #(.width(fir_pkg::acc_w)) u_final_add (
    .a   (part_acc[0]),
    .b   (part_acc[1]),
    .sum (part_sum)
  );

  // partitions are complete one edge before start
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      final_sum <= '0;
    end else if (phase.start) begin
      final_sum <= part_sum;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      filter_out <= '0;
    end else if (phase.load) begin
      filter_out <= final_sum;  // updates only with a new sample
    end
  end

endmodule

//--- mac_partition.sv
`timescale 1ns/1ps

// one serial MAC partition, one tap per enabled cycle
module mac_partition #(
  parameter int part = 0
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  input  fir_pkg::phase_bus_t phase,
  input  fir_pkg::sample_t    tap,
  output fir_pkg::acc_t       acc
);

  fir_pkg::coef_t               coef;      // coefficient for this phase
  logic [fir_pkg::sample_w-1:0] tap_mag;   // |tap|, 0x8000 stays exact
  logic [fir_pkg::coef_w-1:0]   coef_mag;  // |coef|
  logic [fir_pkg::prod_w-1:0]   mag_prod;  // unsigned core result
  logic [fir_pkg::prod_w-1:0]   neg_prod;  // two's complement of mag_prod
  logic                         prod_neg;  // operand signs differ
  fir_pkg::product_t            product;   // sfix32_En31
  fir_pkg::acc_t                prod_ext;  // product widened to sfix33_En31
  fir_pkg::acc_t                acc_sum;   // running sum plus product

  ////////////////////
  // coefficient select
  assign coef = fir_pkg::coeffs[part * fir_pkg::taps_per_part + int'(phase.count)];

  ////////////////////
  // signed multiply around the unsigned core
  assign prod_neg = tap[fir_pkg::sample_w-1] ^ coef[fir_pkg::coef_w-1];
  assign tap_mag  = tap[fir_pkg::sample_w-1] ? -tap : tap;
  assign coef_mag = coef[fir_pkg::coef_w-1] ? -coef : coef;

  vedic_mult #(.width(fir_pkg::sample_w)) u_mult (
    .a       (tap_mag),
    .b       (coef_mag),
    .product (mag_prod)
  );

  // invert and add one
  ripple_adder #(.width(fir_pkg::prod_w)) u_negate (
    .a   (~mag_prod),
    .b   ({{(fir_pkg::prod_w - 1){1'b0}}, 1'b1}),
    .sum (neg_prod)
  );

  assign product  = prod_neg ? neg_prod : mag_prod;
  assign prod_ext = {{(fir_pkg::acc_w - fir_pkg::prod_w){product[fir_pkg::prod_w-1]}}, product};

  ////////////////////
  // accumulator
  ripple_adder #(.width(fir_pkg::acc_w)) u_acc_add (
    .a   (prod_ext),
    .b   (acc),
    .sum (acc_sum)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc <= '0;
    end else if (clk_enable) begin
      if (phase.start) begin
        acc <= prod_ext;  // first tap of a new sample
      end else begin
        acc <= acc_sum;
      end
    end
  end

  // a disabled cycle leaves the running sum untouched
  a_acc_hold : assert property (
    @(posedge clk) disable iff (reset) !clk_enable |=> $stable(acc)
  );

endmodule

//--- tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line (
  input  logic                clk,
  input  logic                reset,
  input  fir_pkg::phase_bus_t phase,
  input  fir_pkg::sample_t    filter_in,
  output fir_pkg::tap_pair_t  taps
);

  // stage 0 holds the newest sample
  fir_pkg::sample_t [fir_pkg::num_taps-1:0] line;

  ////////////////////
  // shift register, advances once per sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      line <= '0;
    end else if (phase.load) begin
      line <= {line[fir_pkg::num_taps-2:0], filter_in};  // shift toward older stages
    end
  end

  ////////////////////
  // tap select, partition p reads stage p*4 + count
  always_comb begin
    for (int p = 0; p < fir_pkg::num_parts; p++) begin
      taps.tap[p] = line[p * fir_pkg::taps_per_part + int'(phase.count)];
    end
  end

endmodule

//--- phase_ctrl.sv
`timescale 1ns/1ps

module phase_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                clk_enable,
  output fir_pkg::phase_bus_t phase
);

  fir_pkg::phase_t count;  // tap phase within one sample period

  // reset to the last phase so the first enabled edge loads a sample
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= fir_pkg::phase_t'(fir_pkg::taps_per_part - 1);
    end else if (clk_enable) begin
      if (count == fir_pkg::phase_t'(fir_pkg::taps_per_part - 1)) begin
        count <= '0;  // wrap
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  always_comb begin
    phase.count = count;
    phase.load  = clk_enable && (count == fir_pkg::phase_t'(fir_pkg::taps_per_part - 1));
    phase.start = clk_enable && (count == '0);
  end

  ////////////////////
  // a sample load and an accumulator restart never share an edge
  a_load_start_apart : assert property (
    @(posedge clk) disable iff (reset) !(phase.load && phase.start)
  );

endmodule

//--- vedic_mult.sv
`timescale 1ns/1ps

// unsigned Urdhva multiplier, recursive down to a 2x2 cell
module vedic_mult #(
  parameter int width = 16
) (
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  output logic [2*width-1:0] product
);

  localparam int half = width / 2;

  generate
    if (width == 2) begin : g_base
      ////////////////////
      // 2x2 cell, AND gates and two half adds
      logic pp_hl;     // a[1] & b[0]
      logic pp_lh;     // a[0] & b[1]
      logic pp_hh;     // a[1] & b[1]
      logic mid_cy;    // carry out of bit 1

      assign pp_hl = a[1] & b[0];
      assign pp_lh = a[0] & b[1];
      assign pp_hh = a[1] & b[1];

      assign product[0] = a[0] & b[0];
      assign product[1] = pp_hl ^ pp_lh;
      assign mid_cy     = pp_hl & pp_lh;
      assign product[2] = pp_hh ^ mid_cy;
      assign product[3] = pp_hh & mid_cy;
    end else begin : g_split
      ////////////////////
      // four half-size products
      logic [width-1:0]      q_ll;    // a lo * b lo
      logic [width-1:0]      q_hl;    // a hi * b lo
      logic [width-1:0]      q_lh;    // a lo * b hi
      logic [width-1:0]      q_hh;    // a hi * b hi
      logic [width-1:0]      sum_lo;  // q_hl + upper half of q_ll
      logic [width+half-1:0] sum_hi;  // q_lh + q_hh shifted up
      logic [width+half-1:0] sum_all;

      vedic_mult #(.width(half)) u_ll (.a(a[half-1:0]), .b(b[half-1:0]), .product(q_ll));
      vedic_mult #(.width(half)) u_hl (.a(a[width-1:half]), .b(b[half-1:0]), .product(q_hl));
      vedic_mult #(.width(half)) u_lh (.a(a[half-1:0]), .b(b[width-1:half]), .product(q_lh));
      vedic_mult #(.width(half)) u_hh (.a(a[width-1:half]), .b(b[width-1:half]),
                                       .product(q_hh));

      // cross terms and shifted partials, all sums exact at these widths
      ripple_adder #(.width(width)) u_add_lo (
        .a   ({{half{1'b0}}, q_ll[width-1:half]}),
        .b   (q_hl),
        .sum (sum_lo)
      );

      ripple_adder #(.width(width + half)) u_add_hi (
        .a   ({{half{1'b0}}, q_lh}),
        .b   ({q_hh, {half{1'b0}}}),
        .sum (sum_hi)
      );

      ripple_adder #(.width(width + half)) u_add_all (
        .a   ({{half{1'b0}}, sum_lo}),
        .b   (sum_hi),
        .sum (sum_all)
      );

      assign product = {sum_all, q_ll[half-1:0]};  // low bits pass straight through
    end
  endgenerate

endmodule

//--- ripple_adder.sv
`timescale 1ns/1ps

// plain ripple-carry adder, carry-in tied low, carry-out dropped
module ripple_adder #(
  parameter int width = 4
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic [width-1:0] sum
);

  logic [width-1:0] carry;  // carry into each bit

  assign carry[0] = 1'b0;

  genvar i;
  generate
    for (i = 0; i < width; i++) begin : g_fa
      logic half_sum;  // a xor b of this bit

      assign half_sum = a[i] ^ b[i];
      assign sum[i]   = half_sum ^ carry[i];

      // top bit forms no carry, result wraps at width
      if (i < width - 1) begin : g_carry
        assign carry[i+1] = (a[i] & b[i]) | (half_sum & carry[i]);
      end
    end
  endgenerate

endmodule

//--- fir_pkg.sv
package fir_pkg;

  ////////////////////
  // widths and tap counts
  localparam int sample_w      = 16;  // sfix16_En15 input
  localparam int coef_w        = 16;  // sfix16_En16 coefficient
  localparam int prod_w        = 32;  // sfix32_En31 full product
  localparam int acc_w         = 33;  // sfix33_En31 accumulator and output
  localparam int num_taps      = 8;
  localparam int num_parts     = 2;
  localparam int taps_per_part = 4;  // num_taps / num_parts

  ////////////////////
  // fixed-point types
  typedef logic signed [sample_w-1:0] sample_t;   // sfix16_En15
  typedef logic signed [coef_w-1:0]   coef_t;     // sfix16_En16
  typedef logic signed [prod_w-1:0]   product_t;  // sfix32_En31
  typedef logic signed [acc_w-1:0]    acc_t;      // sfix33_En31
  typedef logic [$clog2(taps_per_part)-1:0] phase_t;

  ////////////////////
  // symmetric coefficient set, tap order
  localparam coef_t coeffs [num_taps] = '{
    16'hDDBB,  // tap 0
    16'hEA8E,
    16'h33DB,
    16'h6808,
    16'h6808,  // tap 4, first tap of partition 1
    16'h33DB,
    16'hEA8E,
    16'hDDBB
  };

  ////////////////////
  // bundles
  typedef struct packed {
    phase_t count;  // current tap phase
    logic   load;   // sample taken this edge
    logic   start;  // accumulators restart this edge
  } phase_bus_t;

  // one selected tap per partition, index = partition number
  typedef struct packed {
    sample_t [num_parts-1:0] tap;
  } tap_pair_t;

endpackage
